/* build_sim.sh */
#!/bin/sh
# Compile and run the memory access stage testbench with Verilator.
# Run from anywhere; paths are taken relative to the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f mem_access.f \
	--top-module mem_access_tb -Mdir obj_dir -o mem_access_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/mem_access_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

/* mem_access.f */
verilog/mem_access_pkg.sv
verilog/mem_access_ctrl.sv
verilog/store_data_align.sv
verilog/write_mask_gen.sv
verilog/mem_access_top.sv
verification/mem_access_tb.sv

/* verification/mem_access_cases.txt */
// instr seed addr mask reg_lane cache_lane flags(bit2 access, bit1 full, bit0 hit)
// exp_write_mask exp_word_at_cache_lane exp_dwrite exp_rollback
80000000 11223300 0 ffff 0 0 5 8000000000000000 0f000000 1 0
80000000 11223300 1 ffff 0 3 5 0004000000000000 000f0000 1 0
80000000 11223300 2 ffff 0 7 5 0000000200000000 00000f00 1 0
80000000 11223300 3 ffff 0 f 5 0000000000000001 0000000f 1 0
82000000 11223300 1 ffff 0 5 5 0000040000000000 000f0000 1 0
84000000 11223300 0 ffff 0 2 5 00c0000000000000 0f330000 1 0
84000000 11223300 2 ffff 0 9 5 0000000003000000 00000f33 1 0
86000000 11223300 3 ffff 0 e 5 0000000000000030 00000f33 1 0
84000000 11223300 1 ffff 0 1 5 0c00000000000000 0f330000 1 0
88000000 11223300 0 ffff 0 4 5 0000f00000000000 0f332211 1 0
8a000000 11223300 2 ffff 0 b 5 00000000000f0000 0f332211 1 0
8e000000 01020300 0 ffff 0 0 5 ffffffffffffffff 00030201 1 0
90000000 01020300 0 a5c3 0 6 5 f0f00f0fff0000ff 06030201 1 0
92000000 01020300 0 0000 0 3 5 0000000000000000 03030201 1 0
94000000 0a0b0c00 0 ffff 2 2 5 00f0000000000000 020c0b0a 1 0
96000000 0a0b0c00 0 7fff 0 5 5 0000000000000000 000c0b0a 1 0
9a000000 0a0b0c00 0 0001 f c 5 000000000000f000 0f0c0b0a 1 0
9e000000 0a0b0c00 0 0001 e 8 5 0000000000000000 0e0c0b0a 1 0
9c000000 0a0b0c00 0 0100 7 a 5 0000000000f00000 070c0b0a 1 0
88000000 11223300 0 ffff 0 0 6 f000000000000000 0f332211 1 1
a8000000 11223300 0 ffff 0 0 4 f000000000000000 0f332211 0 1
a8000000 11223300 0 ffff 0 0 5 f000000000000000 0f332211 0 0
a8000000 11223300 0 ffff 0 0 0 f000000000000000 0f332211 0 0
88000000 11223300 0 ffff 0 0 2 f000000000000000 0f332211 1 0
a0000000 11223300 2 ffff 0 7 4 0000000200000000 00000f00 0 1
8c000007 11223300 0 ffff 0 3 5 0000000000000000 0f332211 0 0
ac000000 11223300 0 ffff 0 0 5 0000000000000000 0f332211 0 0
40000000 11223300 0 ffff 0 0 1 8000000000000000 0f000000 0 0

/* verification/mem_access_tb.sv */
//--------------------------------------------------------------------------
// Testbench for the memory access stage. Store cases come from
// verification/mem_access_cases.txt, run from the project root.
// Pipeline, flush, control register and halt checks are directed.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_access_tb;
	localparam int FIELDS = 11;	// Tokens per case line
	localparam int MAX_CASES = 32;

	logic clk = 1'b0;
	logic reset_i;
	logic flush_i;
	logic [31:0] instr_word;
	logic [1:0] strand_id_i;
	logic [31:0] pc_i;
	logic [511:0] store_value_i;
	logic [15:0] mask_i;
	logic [3:0] reg_lane_select_i;
	logic [3:0] cache_lane_select_i;
	logic has_writeback_i;
	logic [6:0] writeback_reg_i;
	logic writeback_is_vector_i;
	logic [511:0] result_i;
	logic was_access_i;
	logic cache_hit_i;
	logic dstbuf_full_i;
	logic [511:0] ddata_o;
	logic [63:0] write_mask_o;
	logic dwrite_o;
	logic rollback_request_o;
	logic [31:0] rollback_address_o;
	logic halt_o;
	logic [31:0] instr_out;
	logic [1:0] strand_id_o;
	logic has_writeback_o;
	logic [6:0] writeback_reg_o;
	logic writeback_is_vector_o;
	logic [15:0] mask_o;
	logic [511:0] result_o;
	logic [3:0] reg_lane_select_o;
	logic [3:0] cache_lane_select_o;

	logic [63:0] cases [0:FIELDS*MAX_CASES-1];
	int num_cases = 0;
	int cycle_count = 0;
	int cycle_limit = 100;
	int error_count = 0;

	mem_access_top u_mem_access_top (
		.instruction_i(instr_word),
		.instruction_o(instr_out),
		.*
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
		if (got !== exp)
		begin
			error_count++;
			$display("Error: %s = %h, expected %h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic logic [31:0] byte_swap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Lane k holds seed + k, lane 0 at the top
	function automatic logic [511:0] build_line(input logic [31:0] seed);
		logic [511:0] line;
		for (int k = 0; k < 16; k++)
			line[(15 - k) * 32 +: 32] = seed + 32'(k);
		return line;
	endfunction

	function automatic logic [511:0] expected_line(input logic [3:0] op,
		input logic [31:0] seed, input logic [1:0] addr, input logic [3:0] rlane);
		logic [511:0] line;
		logic [31:0] low_word;
		logic [31:0] word;
		low_word = seed + 32'd15;	// Lane 15 is the low word
		word = byte_swap(low_word);
		case (op)
			4'd0, 4'd1:
			begin
				word = '0;
				word[(3 - int'(addr)) * 8 +: 8] = low_word[7:0];
			end
			4'd2, 4'd3:
			begin
				word = '0;
				word[(1 - int'(addr[1])) * 16 +: 16] = {low_word[7:0], low_word[15:8]};
			end
			4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15:
				word = byte_swap(seed + 32'(rlane));
			default:
				word = byte_swap(low_word);
		endcase
		for (int k = 0; k < 16; k++)
			line[(15 - k) * 32 +: 32] = (op >= 4'd7 && op <= 4'd9)
				? byte_swap(seed + 32'(k)) : word;
		return line;
	endfunction

	task automatic check_pipeline(input logic [31:0] instr, input logic [1:0] strand,
		input logic wb, input logic [6:0] wb_reg, input logic wb_vec,
		input logic [15:0] msk, input logic [511:0] res, input logic [3:0] rl,
		input logic [3:0] cl);
		check("instruction_o", 512'(instr_out), 512'(instr));
		check("strand_id_o", 512'(strand_id_o), 512'(strand));
		check("has_writeback_o", 512'(has_writeback_o), 512'(wb));
		check("writeback_reg_o", 512'(writeback_reg_o), 512'(wb_reg));
		check("writeback_is_vector_o", 512'(writeback_is_vector_o), 512'(wb_vec));
		check("mask_o", 512'(mask_o), 512'(msk));
		check("result_o", result_o, res);
		check("reg_lane_select_o", 512'(reg_lane_select_o), 512'(rl));
		check("cache_lane_select_o", 512'(cache_lane_select_o), 512'(cl));
	endtask

	task automatic run_case(input int c);
		int base;
		int lane_pos;
		logic [511:0] exp_line;
		base = c * FIELDS;
		lane_pos = 15 - int'(cases[base+5][3:0]);
		exp_line = expected_line(cases[base][28:25], cases[base+1][31:0],
			cases[base+2][1:0], cases[base+4][3:0]);
		@(posedge clk);
		instr_word <= cases[base][31:0];
		store_value_i <= build_line(cases[base+1][31:0]);
		result_i <= {510'd0, cases[base+2][1:0]};
		mask_i <= cases[base+3][15:0];
		reg_lane_select_i <= cases[base+4][3:0];
		cache_lane_select_i <= cases[base+5][3:0];
		cache_hit_i <= cases[base+6][0];
		dstbuf_full_i <= cases[base+6][1];
		was_access_i <= cases[base+6][2];
		pc_i <= 32'h0000_1000 + 32'(c) * 32'd4;
		@(negedge clk);
		check("write_mask_o", 512'(write_mask_o), 512'(cases[base+7]));
		check("ddata_o at cache lane", 512'(ddata_o[lane_pos*32 +: 32]),
			512'(cases[base+8][31:0]));
		check("ddata_o", ddata_o, exp_line);
		check("dwrite_o", 512'(dwrite_o), 512'(cases[base+9][0]));
		check("rollback_request_o", 512'(rollback_request_o), 512'(cases[base+10][0]));
		check("rollback_address_o", 512'(rollback_address_o),
			512'(32'h0000_0ffc + 32'(c) * 32'd4));	// One word before the case PC
	endtask

	task automatic pass_through_test();
		logic [31:0] instr_v;
		logic [1:0] strand_v;
		logic wb_v;
		logic [6:0] wb_reg_v;
		logic wb_vec_v;
		logic [15:0] mask_v;
		logic [511:0] result_v;
		logic [3:0] rlane_v;
		logic [3:0] clane_v;
		for (int n = 0; n < 4; n++)
		begin
			instr_v = $urandom() & 32'h3fff_ffff;	// Never memory format
			strand_v = 2'($urandom());
			wb_v = 1'($urandom());
			wb_reg_v = 7'($urandom());
			wb_vec_v = 1'($urandom());
			mask_v = 16'($urandom());
			rlane_v = 4'($urandom());
			clane_v = 4'($urandom());
			for (int k = 0; k < 16; k++)
				result_v[k*32 +: 32] = $urandom();
			@(posedge clk);
			instr_word <= instr_v;
			strand_id_i <= strand_v;
			has_writeback_i <= wb_v;
			writeback_reg_i <= wb_reg_v;
			writeback_is_vector_i <= wb_vec_v;
			mask_i <= mask_v;
			result_i <= result_v;
			reg_lane_select_i <= rlane_v;
			cache_lane_select_i <= clane_v;
			was_access_i <= 1'b0;
			@(posedge clk);
			@(negedge clk);
			check_pipeline(instr_v, strand_v, wb_v, wb_reg_v, wb_vec_v, mask_v,
				result_v, rlane_v, clane_v);
		end
	endtask

	initial
	begin
		logic [31:0] scratch_v;
		void'($urandom(15));
		for (int i = 0; i < FIELDS * MAX_CASES; i++)
			cases[i] = '0;
		$readmemh("verification/mem_access_cases.txt", cases);
		while (num_cases < MAX_CASES && cases[num_cases*FIELDS] != 64'd0)
			num_cases++;
		cycle_limit = num_cases * 4 + 100;

		// Pipeline inputs nonzero while reset clears the registers
		reset_i <= 1'b1;
		flush_i <= 1'b0;
		instr_word <= 32'h1234_5678;
		strand_id_i <= 2'd2;
		pc_i <= '0;
		store_value_i <= '0;
		mask_i <= 16'ha5a5;
		reg_lane_select_i <= 4'h9;
		cache_lane_select_i <= 4'h6;
		has_writeback_i <= 1'b1;
		writeback_reg_i <= 7'h55;
		writeback_is_vector_i <= 1'b1;
		result_i <= {16{32'h5a5a_c3c3}};
		was_access_i <= 1'b0;
		cache_hit_i <= 1'b0;
		dstbuf_full_i <= 1'b0;
		repeat (10) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_pipeline('0, '0, 1'b0, '0, 1'b0, '0, '0, '0, '0);
		check("halt_o", 512'(halt_o), '0);

		for (int c = 0; c < num_cases; c++)
			run_case(c);

		pass_through_test();
		@(posedge clk);
		flush_i <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		check_pipeline('0, '0, 1'b0, '0, 1'b0, '0, '0, '0, '0);

		// cr7 write, cr7 read, then strand ID read
		scratch_v = $urandom();
		@(posedge clk);
		flush_i <= 1'b0;
		instr_word <= 32'h8c00_0007;
		store_value_i <= {480'd0, scratch_v};
		was_access_i <= 1'b0;
		@(negedge clk);
		check("dwrite_o", 512'(dwrite_o), '0);
		check("write_mask_o", 512'(write_mask_o), '0);
		@(posedge clk);
		instr_word <= 32'hac00_0007;
		store_value_i <= '0;
		@(posedge clk);
		instr_word <= 32'hac00_0000;
		strand_id_i <= 2'd3;
		@(negedge clk);
		check("result_o", result_o, {480'd0, scratch_v});
		@(posedge clk);
		instr_word <= 32'h0;
		@(negedge clk);
		check("result_o", result_o, {480'd0, mem_access_pkg::CORE_ID, 2'b11});

		// Halt rises after the cr31 write and sticks
		@(posedge clk);
		instr_word <= 32'h8c00_001f;
		@(negedge clk);
		check("halt_o", 512'(halt_o), '0);
		@(posedge clk);
		instr_word <= 32'h0;
		@(negedge clk);
		check("halt_o", 512'(halt_o), 512'(1));
		repeat (3) @(posedge clk);
		@(negedge clk);
		check("halt_o", 512'(halt_o), 512'(1));

		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end
endmodule

`default_nettype wire

/* verilog/mem_access_ctrl.sv */
//--------------------------------------------------------------------------
// Decode, rollback and control registers of the memory access stage.
// Never stalls; a miss or full store buffer only requests a rollback.
// Halt is sticky until reset.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic flush_i,
	input mem_access_pkg::instr_u instruction_i,
	input wire logic [1:0] strand_id_i,
	input wire logic [31:0] pc_i,
	input wire logic [mem_access_pkg::LINE_W-1:0] store_value_i,
	input wire logic [mem_access_pkg::LINE_W-1:0] result_i,
	input wire logic [mem_access_pkg::LANES-1:0] mask_i,
	input wire logic [3:0] reg_lane_select_i,
	input wire logic [3:0] cache_lane_select_i,
	input wire logic has_writeback_i,
	input wire logic [6:0] writeback_reg_i,
	input wire logic writeback_is_vector_i,
	input wire logic was_access_i,
	input wire logic cache_hit_i,
	input wire logic dstbuf_full_i,
	output logic is_cr_transfer_o,
	output logic dwrite_o,
	output logic rollback_request_o,
	output logic [31:0] rollback_address_o,
	output logic halt_o,
	output mem_access_pkg::instr_u instruction_o,
	output logic [1:0] strand_id_o,
	output logic has_writeback_o,
	output logic [6:0] writeback_reg_o,
	output logic writeback_is_vector_o,
	output logic [mem_access_pkg::LANES-1:0] mask_o,
	output logic [mem_access_pkg::LINE_W-1:0] result_o,
	output logic [3:0] reg_lane_select_o,
	output logic [3:0] cache_lane_select_o
);
	logic is_mem_fmt;
	logic cr_write;
	logic [31:0] cr_scratch;
	logic [mem_access_pkg::LINE_W-1:0] result_nxt;

	assign is_mem_fmt = instruction_i.mem.fmt == mem_access_pkg::FMT_MEM;
	assign is_cr_transfer_o = is_mem_fmt
		&& instruction_i.mem.op_type == mem_access_pkg::OP_CTRL_REG;
	assign cr_write = is_cr_transfer_o && !instruction_i.cr.is_load;

	// Store still flagged when buffer is full, so the cache skips the load
	assign dwrite_o = is_mem_fmt && !instruction_i.mem.is_load && !is_cr_transfer_o;

	assign rollback_request_o = was_access_i
		&& (instruction_i.mem.is_load ? !cache_hit_i : dstbuf_full_i);
	assign rollback_address_o = pc_i - 32'd4;	// Re-issue this instruction

	// Reads from control registers replace the result
	always_comb
	begin
		result_nxt = result_i;
		if (is_cr_transfer_o)
		begin
			case (instruction_i.cr.cr_index)
				mem_access_pkg::CR_STRAND:
					result_nxt = {{(mem_access_pkg::LINE_W - 32){1'b0}},
						mem_access_pkg::CORE_ID, strand_id_i};
				mem_access_pkg::CR_SCRATCH:
					result_nxt = {{(mem_access_pkg::LINE_W - 32){1'b0}}, cr_scratch};
				default:
					result_nxt = '0;
			endcase
		end
	end

	// Writes to control registers
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			cr_scratch <= '0;
			halt_o <= 1'b0;
		end
		else if (cr_write)
		begin
			if (instruction_i.cr.cr_index == mem_access_pkg::CR_SCRATCH)
				cr_scratch <= store_value_i[31:0];
			else if (instruction_i.cr.cr_index == mem_access_pkg::CR_HALT)
				halt_o <= 1'b1;	// Any value halts
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset_i || flush_i)
		begin
			instruction_o <= '0;
			strand_id_o <= '0;
			has_writeback_o <= 1'b0;
			writeback_reg_o <= '0;
			writeback_is_vector_o <= 1'b0;
			mask_o <= '0;
			result_o <= '0;
			reg_lane_select_o <= '0;
			cache_lane_select_o <= '0;
		end
		else
		begin
			instruction_o <= instruction_i;
			strand_id_o <= strand_id_i;
			has_writeback_o <= has_writeback_i;
			writeback_reg_o <= writeback_reg_i;
			writeback_is_vector_o <= writeback_is_vector_i;
			mask_o <= mask_i;
			result_o <= result_nxt;
			reg_lane_select_o <= reg_lane_select_i;
			cache_lane_select_o <= cache_lane_select_i;
		end
	end
endmodule

`default_nettype wire

/* verilog/mem_access_pkg.sv */
//--------------------------------------------------------------------------
// Shared types and constants for the memory access stage.
// Lane 0 is the most significant 32-bit word of a cache line.
//--------------------------------------------------------------------------
`default_nettype none

package mem_access_pkg;
	localparam int LINE_W = 512;
	localparam int LANES = 16;
	localparam int MASK_W = 64;

	localparam logic [29:0] CORE_ID = 30'd0;	// Upper bits of strand ID read

	localparam logic [1:0] FMT_MEM = 2'b10;

	// Control register numbers
	localparam logic [4:0] CR_STRAND = 5'd0;
	localparam logic [4:0] CR_SCRATCH = 5'd7;
	localparam logic [4:0] CR_HALT = 5'd31;

	typedef enum logic [3:0] {
		OP_BYTE = 4'd0,
		OP_BYTE_SIGNED = 4'd1,
		OP_HALF = 4'd2,
		OP_HALF_SIGNED = 4'd3,
		OP_WORD = 4'd4,
		OP_WORD_SYNC = 4'd5,
		OP_CTRL_REG = 4'd6,		// Control register transfer in memory format
		OP_BLOCK = 4'd7,
		OP_BLOCK_MASK = 4'd8,
		OP_BLOCK_INVMASK = 4'd9,
		OP_STRIDED = 4'd10,
		OP_STRIDED_MASK = 4'd11,
		OP_STRIDED_INVMASK = 4'd12,
		OP_SCATTER = 4'd13,
		OP_SCATTER_MASK = 4'd14,
		OP_SCATTER_INVMASK = 4'd15
	} op_type_e;

	// Same word, seen as a memory access or as a control register transfer
	typedef union packed {
		struct packed {
			logic [1:0] fmt;
			logic is_load;
			op_type_e op_type;
			logic [19:0] middle;
			logic [4:0] reg_num;
		} mem;
		struct packed {
			logic [1:0] fmt;
			logic is_load;
			op_type_e op_type;
			logic [19:0] middle;
			logic [4:0] cr_index;
		} cr;
	} instr_u;
endpackage

`default_nettype wire

/* verilog/mem_access_top.sv */
//--------------------------------------------------------------------------
// Memory access stage of one core. Cache outputs are combinational,
// pipeline fields are registered and cleared by flush.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_access_top (
	input wire logic clk,
	input wire logic reset_i,
	input wire logic flush_i,
	input mem_access_pkg::instr_u instruction_i,
	input wire logic [1:0] strand_id_i,
	input wire logic [31:0] pc_i,
	input wire logic [mem_access_pkg::LINE_W-1:0] store_value_i,
	input wire logic [mem_access_pkg::LANES-1:0] mask_i,
	input wire logic [3:0] reg_lane_select_i,
	input wire logic [3:0] cache_lane_select_i,
	input wire logic has_writeback_i,
	input wire logic [6:0] writeback_reg_i,
	input wire logic writeback_is_vector_i,
	input wire logic [mem_access_pkg::LINE_W-1:0] result_i,
	input wire logic was_access_i,
	input wire logic cache_hit_i,
	input wire logic dstbuf_full_i,
	output logic [mem_access_pkg::LINE_W-1:0] ddata_o,
	output logic [mem_access_pkg::MASK_W-1:0] write_mask_o,
	output logic dwrite_o,
	output logic rollback_request_o,
	output logic [31:0] rollback_address_o,
	output logic halt_o,
	output mem_access_pkg::instr_u instruction_o,
	output logic [1:0] strand_id_o,
	output logic has_writeback_o,
	output logic [6:0] writeback_reg_o,
	output logic writeback_is_vector_o,
	output logic [mem_access_pkg::LANES-1:0] mask_o,
	output logic [mem_access_pkg::LINE_W-1:0] result_o,
	output logic [3:0] reg_lane_select_o,
	output logic [3:0] cache_lane_select_o
);
	logic is_cr_transfer;
	logic [3:0] byte_mask;

	mem_access_ctrl u_ctrl (
		.clk, .reset_i, .flush_i, .instruction_i, .strand_id_i, .pc_i,
		.store_value_i, .result_i, .mask_i, .reg_lane_select_i,
		.cache_lane_select_i, .has_writeback_i, .writeback_reg_i,
		.writeback_is_vector_i, .was_access_i, .cache_hit_i, .dstbuf_full_i,
		.is_cr_transfer_o(is_cr_transfer),
		.dwrite_o, .rollback_request_o, .rollback_address_o, .halt_o,
		.instruction_o, .strand_id_o, .has_writeback_o, .writeback_reg_o,
		.writeback_is_vector_o, .mask_o, .result_o, .reg_lane_select_o,
		.cache_lane_select_o
	);

	store_data_align u_align (
		.instruction_i,
		.store_value_i,
		.addr_low_i(result_i[1:0]),	// Byte offset within the word
		.reg_lane_select_i,
		.ddata_o,
		.byte_mask_o(byte_mask)
	);

	write_mask_gen u_mask (
		.instruction_i,
		.is_cr_transfer_i(is_cr_transfer),
		.mask_i,
		.reg_lane_select_i,
		.cache_lane_select_i,
		.byte_mask_i(byte_mask),
		.write_mask_o
	);
endmodule

`default_nettype wire

/* verilog/store_data_align.sv */
//--------------------------------------------------------------------------
// Places store data on the cache line in big-endian byte order.
// Scalar data is replicated into every word; the write mask picks the lane.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module store_data_align (
	input mem_access_pkg::instr_u instruction_i,
	input wire logic [mem_access_pkg::LINE_W-1:0] store_value_i,
	input wire logic [1:0] addr_low_i,
	input wire logic [3:0] reg_lane_select_i,
	output logic [mem_access_pkg::LINE_W-1:0] ddata_o,
	output logic [3:0] byte_mask_o
);
	logic [mem_access_pkg::LINE_W-1:0] swapped_line;
	logic [31:0] lane_value;
	logic [31:0] scalar_word;

	function automatic logic [31:0] swap32(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Lane 0 sits at the top of the line
	assign lane_value = store_value_i[{~reg_lane_select_i, 5'd0} +: 32];

	for (genvar i = 0; i < mem_access_pkg::LANES; i++)
	begin : g_swap
		assign swapped_line[i*32 +: 32] = swap32(store_value_i[i*32 +: 32]);
	end

	always_comb
	begin
		byte_mask_o = 4'b1111;
		scalar_word = swap32(store_value_i[31:0]);
		ddata_o = swapped_line;
		case (instruction_i.mem.op_type)
			mem_access_pkg::OP_BYTE, mem_access_pkg::OP_BYTE_SIGNED:
			begin
				byte_mask_o = 4'b1000 >> addr_low_i;
				scalar_word = {store_value_i[7:0], 24'd0} >> {addr_low_i, 3'b000};
				ddata_o = {mem_access_pkg::LANES{scalar_word}};
			end

			mem_access_pkg::OP_HALF, mem_access_pkg::OP_HALF_SIGNED:
			begin
				byte_mask_o = 4'b1100 >> {addr_low_i[1], 1'b0};
				scalar_word = {store_value_i[7:0], store_value_i[15:8], 16'd0}
					>> {addr_low_i[1], 4'b0000};
				ddata_o = {mem_access_pkg::LANES{scalar_word}};
			end

			mem_access_pkg::OP_WORD, mem_access_pkg::OP_WORD_SYNC,
			mem_access_pkg::OP_CTRL_REG:
				ddata_o = {mem_access_pkg::LANES{scalar_word}};

			mem_access_pkg::OP_STRIDED, mem_access_pkg::OP_STRIDED_MASK,
			mem_access_pkg::OP_STRIDED_INVMASK,
			mem_access_pkg::OP_SCATTER, mem_access_pkg::OP_SCATTER_MASK,
			mem_access_pkg::OP_SCATTER_INVMASK:
			begin
				scalar_word = swap32(lane_value);	// One register lane
				ddata_o = {mem_access_pkg::LANES{scalar_word}};
			end

			default:	// Block vector
				ddata_o = swapped_line;
		endcase
	end
endmodule

`default_nettype wire

/* verilog/write_mask_gen.sv */
//--------------------------------------------------------------------------
// Byte write enables for one cache line, lane 0 most significant.
// Control register transfers enable no bytes.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module write_mask_gen (
	input mem_access_pkg::instr_u instruction_i,
	input wire logic is_cr_transfer_i,
	input wire logic [mem_access_pkg::LANES-1:0] mask_i,
	input wire logic [3:0] reg_lane_select_i,
	input wire logic [3:0] cache_lane_select_i,
	input wire logic [3:0] byte_mask_i,
	output logic [mem_access_pkg::MASK_W-1:0] write_mask_o
);
	logic [mem_access_pkg::LANES-1:0] cache_lane_bit;
	logic [mem_access_pkg::LANES-1:0] word_mask;

	assign cache_lane_bit = {1'b1, {(mem_access_pkg::LANES - 1){1'b0}}} >> cache_lane_select_i;

	always_comb
	begin
		case (instruction_i.mem.op_type)
			mem_access_pkg::OP_BLOCK, mem_access_pkg::OP_BLOCK_MASK,
			mem_access_pkg::OP_BLOCK_INVMASK:
				word_mask = mask_i;

			mem_access_pkg::OP_STRIDED, mem_access_pkg::OP_STRIDED_MASK,
			mem_access_pkg::OP_STRIDED_INVMASK,
			mem_access_pkg::OP_SCATTER, mem_access_pkg::OP_SCATTER_MASK,
			mem_access_pkg::OP_SCATTER_INVMASK:
			begin
				// Only if the register lane is active
				if (mask_i[~reg_lane_select_i])
					word_mask = cache_lane_bit;
				else
					word_mask = '0;
			end

			default:	// Scalar
				word_mask = cache_lane_bit;
		endcase

		if (is_cr_transfer_i)
			word_mask = '0;
	end

	for (genvar i = 0; i < mem_access_pkg::LANES; i++)
	begin : g_expand
		assign write_mask_o[i*4 +: 4] = {4{word_mask[i]}} & byte_mask_i;	// Four bytes per word
	end
endmodule

`default_nettype wire
